/* include/pio_macros.svh */
`ifndef PIO_MACROS_SVH
`define PIO_MACROS_SVH

// Block sizes
`define PIO_NUM_SM      4
`define PIO_IMEM_DEPTH  32
`define PIO_FIFO_DEPTH  4
`define PIO_DIV_W       16

// Derived widths
`define PIO_SM_IDX_W    2
`define PIO_PC_W        5
`define PIO_WORD_W      32

// Pin groups per instruction class
`define PIO_SET_MAX     5

`endif

/* src/pio_pkg.sv */
package pio_pkg;

  typedef logic [31:0] word_t;

  typedef enum logic [2:0] {
    OP_JMP      = 3'd0,
    OP_WAIT     = 3'd1,
    OP_IN       = 3'd2,
    OP_OUT      = 3'd3,
    OP_PUSHPULL = 3'd4,
    OP_SET      = 3'd7
  } opcode_e;

  // 16-bit instruction word
  typedef struct packed {
    opcode_e    op;    // 15:13
    logic [4:0] rsvd;  // 12:8, ignored
    logic [2:0] sub;   // 7:5
    logic [4:0] arg;   // 4:0
  } instr_t;

  typedef enum logic [3:0] {
    ACT_IDLE     = 4'd0,
    ACT_WR_INSTR = 4'd1,
    ACT_WRAP     = 4'd2,
    ACT_POP_RX   = 4'd3,
    ACT_PUSH_TX  = 4'd4,
    ACT_PINS     = 4'd5,
    ACT_ENABLE   = 4'd6,
    ACT_DIV      = 4'd7,
    ACT_IMM      = 4'd9,
    ACT_JMP_PIN  = 4'd10
  } action_e;

endpackage

/* src/pio_ctrl.sv */
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [3:0]                action,
  input  logic [`PIO_SM_IDX_W-1:0]  mindex,
  input  logic [`PIO_PC_W-1:0]      index,
  input  pio_pkg::word_t            din,
  input  logic [`PIO_PC_W-1:0]      pc [`PIO_NUM_SM],
  output pio_pkg::instr_t           instr_word [`PIO_NUM_SM],
  output logic [`PIO_NUM_SM-1:0]    imm_stb,
  output pio_pkg::instr_t           imm_instr,
  output logic [`PIO_NUM_SM-1:0]    sm_en,
  output logic [`PIO_PC_W-1:0]      wrap_start [`PIO_NUM_SM],
  output logic [`PIO_PC_W-1:0]      wrap_end [`PIO_NUM_SM],
  output logic [4:0]                out_base [`PIO_NUM_SM],
  output logic [5:0]                out_count [`PIO_NUM_SM],
  output logic [4:0]                set_base [`PIO_NUM_SM],
  output logic [2:0]                set_count [`PIO_NUM_SM],
  output logic [4:0]                jmp_pin_idx [`PIO_NUM_SM],
  output logic [`PIO_DIV_W-1:0]     div [`PIO_NUM_SM],
  output logic [`PIO_NUM_SM-1:0]    host_push,
  output logic [`PIO_NUM_SM-1:0]    host_pop
);

  pio_pkg::action_e act;
  logic [`PIO_NUM_SM-1:0] sm_sel;
  pio_pkg::instr_t imem [`PIO_IMEM_DEPTH];  // Shared by all machines

  assign act = pio_pkg::action_e'(action);
  assign sm_sel = `PIO_NUM_SM'(1) << mindex;

  // FIFO strobes land on the same edge as the action
  assign host_push = (act == pio_pkg::ACT_PUSH_TX) ? sm_sel : '0;
  assign host_pop  = (act == pio_pkg::ACT_POP_RX) ? sm_sel : '0;

  always_ff @(posedge clk) begin
    if (act == pio_pkg::ACT_WR_INSTR) begin
      imem[index] <= pio_pkg::instr_t'(din[15:0]);
    end
  end

  // Each machine fetches at its own pc
  always_comb begin
    for (int i = 0; i < `PIO_NUM_SM; i++) begin
      instr_word[i] = imem[pc[i]];
    end
  end

  always_ff @(posedge clk) begin
    if (act == pio_pkg::ACT_IMM) begin
      imm_instr <= pio_pkg::instr_t'(din[15:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sm_en   <= '0;
      imm_stb <= '0;
      for (int i = 0; i < `PIO_NUM_SM; i++) begin
        wrap_start[i]  <= '0;
        wrap_end[i]    <= '1;  // Whole memory
        out_base[i]    <= '0;
        out_count[i]   <= '0;
        set_base[i]    <= '0;
        set_count[i]   <= '0;
        jmp_pin_idx[i] <= '0;
        div[i]         <= '0;
      end
    end else begin
      imm_stb <= (act == pio_pkg::ACT_IMM) ? sm_sel : '0;
      case (act)
        pio_pkg::ACT_WRAP: begin
          wrap_end[mindex]   <= index;
          wrap_start[mindex] <= din[4:0];
        end
        pio_pkg::ACT_PINS: begin
          out_base[mindex]  <= din[4:0];
          out_count[mindex] <= din[10:5];
          set_base[mindex]  <= din[15:11];
          set_count[mindex] <= din[18:16];
        end
        pio_pkg::ACT_ENABLE:  sm_en <= din[`PIO_NUM_SM-1:0];
        pio_pkg::ACT_DIV:     div[mindex] <= din[`PIO_DIV_W-1:0];
        pio_pkg::ACT_JMP_PIN: jmp_pin_idx[mindex] <= din[4:0];
        default: ;
      endcase
    end
  end

  a_wr_index: assert property (@(posedge clk) disable iff (reset)
    (act == pio_pkg::ACT_WR_INSTR) |-> !$isunknown(index))
    else $error("pio_ctrl: instruction write to an unknown slot");

endmodule

/* src/pio_fifo.sv */
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio_fifo (
  input  logic           clk,
  input  logic           reset,
  input  logic           push,
  input  logic           pop,
  input  pio_pkg::word_t din,
  output pio_pkg::word_t dout,
  output logic           empty,
  output logic           full
);

  localparam int AW = $clog2(`PIO_FIFO_DEPTH);

  pio_pkg::word_t mem [`PIO_FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign empty   = (count == '0);
  assign full    = (count == (AW+1)'(`PIO_FIFO_DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign dout    = mem[rd_ptr];  // Head word

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + AW'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
      count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else $error("pio_fifo: push while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
    else $error("pio_fifo: pop while empty");

endmodule

/* src/pio_machine.sv */
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio_machine (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  en,
  input  logic                  imm_stb,
  input  pio_pkg::instr_t       imm_instr,
  input  pio_pkg::instr_t       instr_word,
  input  logic [`PIO_PC_W-1:0]  wrap_start,
  input  logic [`PIO_PC_W-1:0]  wrap_end,
  input  logic [4:0]            out_base,
  input  logic [5:0]            out_count,
  input  logic [4:0]            set_base,
  input  logic [2:0]            set_count,
  input  logic [4:0]            jmp_pin_idx,
  input  logic [`PIO_DIV_W-1:0] div,
  input  pio_pkg::word_t        gpio_in,
  input  pio_pkg::word_t        tx_data,
  input  logic                  tx_empty,
  input  logic                  rx_full,
  output logic [`PIO_PC_W-1:0]  pc,
  output logic                  pull,
  output logic                  push,
  output pio_pkg::word_t        rx_data,
  output pio_pkg::word_t        pin_val,
  output pio_pkg::word_t        pin_mask
);

  logic [`PIO_DIV_W-1:0] div_cnt;
  logic                  tick;
  logic                  exec;
  logic                  stall;
  logic                  taken;
  logic                  do_pin;
  pio_pkg::instr_t       cur;
  pio_pkg::word_t        x;
  pio_pkg::word_t        isr;
  pio_pkg::word_t        osr;
  pio_pkg::word_t        nmask;
  pio_pkg::word_t        in_src;
  pio_pkg::word_t        pin_src;
  pio_pkg::word_t        pin_wmask;
  logic [5:0]            nbits;
  logic [5:0]            pin_width;
  logic [5:0]            out_lim;
  logic [5:0]            set_lim;
  logic [4:0]            pin_base;
  logic [`PIO_PC_W-1:0]  pc_seq;

  function automatic pio_pkg::word_t rotl(pio_pkg::word_t v, logic [4:0] s);
    return (v << s) | (v >> (6'd32 - {1'b0, s}));
  endfunction

  assign tick = en && (div_cnt == div);
  assign exec = imm_stb || tick;          // Immediate wins over program
  assign cur  = imm_stb ? imm_instr : instr_word;

  always_ff @(posedge clk) begin
    if (reset || !en || tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign nbits   = (cur.arg == '0) ? 6'd32 : {1'b0, cur.arg};  // 0 means 32
  assign nmask   = ~(32'hFFFF_FFFF << nbits);
  assign in_src  = (cur.sub == 3'd1) ? x : (gpio_in >> out_base);
  assign pc_seq  = (pc == wrap_end) ? wrap_start : pc + 1'b1;
  assign rx_data = isr;

  // A zero count opens the full group
  assign out_lim = (out_count == '0 || out_count > 6'd32) ? 6'd32 : out_count;
  assign set_lim = (set_count == '0 || set_count > 3'(`PIO_SET_MAX)) ?
                   6'(`PIO_SET_MAX) : {3'b0, set_count};

  always_comb begin
    stall     = 1'b0;
    taken     = 1'b0;
    do_pin    = 1'b0;
    pin_base  = out_base;
    pin_width = (nbits < out_lim) ? nbits : out_lim;
    pin_src   = osr & nmask;
    case (cur.op)
      pio_pkg::OP_JMP: begin
        case (cur.sub)
          3'd0: taken = 1'b1;
          3'd1: taken = (x == '0);
          3'd2: taken = (x != '0);
          3'd3: taken = gpio_in[jmp_pin_idx];
          default: taken = 1'b0;
        endcase
      end
      pio_pkg::OP_WAIT:     stall = (gpio_in[cur.arg] != cur.sub[0]);
      pio_pkg::OP_OUT:      do_pin = (cur.sub == 3'd0);
      pio_pkg::OP_PUSHPULL: stall = cur.sub[0] ? tx_empty : rx_full;
      pio_pkg::OP_SET: begin
        do_pin    = (cur.sub == 3'd0);
        pin_base  = set_base;
        pin_width = set_lim;
        pin_src   = 32'(cur.arg);
      end
      default: ;
    endcase
    pin_wmask = rotl(~(32'hFFFF_FFFF << pin_width), pin_base);
  end

  // Strobes meet the FIFO on the executing edge
  assign pull = exec && (cur.op == pio_pkg::OP_PUSHPULL) && cur.sub[0] && !tx_empty;
  assign push = exec && (cur.op == pio_pkg::OP_PUSHPULL) && !cur.sub[0] && !rx_full;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= '0;
      x        <= '0;
      isr      <= '0;
      osr      <= '0;
      pin_val  <= '0;
      pin_mask <= '0;
    end else if (exec && !stall) begin  // A stalled immediate is dropped
      if (taken) begin
        pc <= cur.arg;
      end else if (!imm_stb) begin
        pc <= pc_seq;
      end
      case (cur.op)
        pio_pkg::OP_JMP: begin
          if (cur.sub == 3'd2) begin
            x <= x - 1'b1;
          end
        end
        pio_pkg::OP_IN: isr <= (isr << nbits) | (in_src & nmask);
        pio_pkg::OP_OUT: begin
          osr <= osr >> nbits;
          if (cur.sub == 3'd1) begin
            x <= osr & nmask;
          end
        end
        pio_pkg::OP_PUSHPULL: begin
          if (cur.sub[0]) begin
            osr <= tx_data;
          end else begin
            isr <= '0;
          end
        end
        pio_pkg::OP_SET: begin
          if (cur.sub == 3'd1) begin
            x <= 32'(cur.arg);
          end
        end
        default: ;
      endcase
      if (do_pin) begin
        pin_val  <= (pin_val & ~pin_wmask) | (rotl(pin_src, pin_base) & pin_wmask);
        pin_mask <= pin_mask | pin_wmask;
      end
    end
  end

  a_pc_range: assert property (@(posedge clk) disable iff (reset) !$isunknown(pc))
    else $error("pio_machine: pc unknown");

endmodule

/* src/pio_pin_merge.sv */
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio_pin_merge (
  input  pio_pkg::word_t pin_val [`PIO_NUM_SM],
  input  pio_pkg::word_t pin_mask [`PIO_NUM_SM],
  output pio_pkg::word_t gpio_out,
  output pio_pkg::word_t gpio_dir
);

  // Later machines overwrite earlier ones
  always_comb begin
    gpio_out = '0;
    gpio_dir = '0;
    for (int m = 0; m < `PIO_NUM_SM; m++) begin
      gpio_out = (gpio_out & ~pin_mask[m]) | (pin_val[m] & pin_mask[m]);
      gpio_dir = gpio_dir | pin_mask[m];
    end
  end

endmodule

/* src/pio.sv */
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [3:0]               action,
  input  logic [`PIO_SM_IDX_W-1:0] mindex,
  input  logic [`PIO_PC_W-1:0]     index,
  input  pio_pkg::word_t           din,
  input  pio_pkg::word_t           gpio_in,
  output pio_pkg::word_t           dout,
  output logic [`PIO_NUM_SM-1:0]   tx_full,
  output logic [`PIO_NUM_SM-1:0]   rx_empty,
  output pio_pkg::word_t           gpio_out,
  output pio_pkg::word_t           gpio_dir
);

  pio_pkg::instr_t        instr_word [`PIO_NUM_SM];
  pio_pkg::instr_t        imm_instr;
  logic [`PIO_NUM_SM-1:0] imm_stb;
  logic [`PIO_NUM_SM-1:0] sm_en;
  logic [`PIO_PC_W-1:0]   pc [`PIO_NUM_SM];
  logic [`PIO_PC_W-1:0]   wrap_start [`PIO_NUM_SM];
  logic [`PIO_PC_W-1:0]   wrap_end [`PIO_NUM_SM];
  logic [4:0]             out_base [`PIO_NUM_SM];
  logic [5:0]             out_count [`PIO_NUM_SM];
  logic [4:0]             set_base [`PIO_NUM_SM];
  logic [2:0]             set_count [`PIO_NUM_SM];
  logic [4:0]             jmp_pin_idx [`PIO_NUM_SM];
  logic [`PIO_DIV_W-1:0]  div [`PIO_NUM_SM];
  logic [`PIO_NUM_SM-1:0] host_push;
  logic [`PIO_NUM_SM-1:0] host_pop;
  logic [`PIO_NUM_SM-1:0] sm_pull;
  logic [`PIO_NUM_SM-1:0] sm_push;
  logic [`PIO_NUM_SM-1:0] tx_empty;
  logic [`PIO_NUM_SM-1:0] rx_full;
  pio_pkg::word_t         tx_data [`PIO_NUM_SM];
  pio_pkg::word_t         rx_data [`PIO_NUM_SM];
  pio_pkg::word_t         rx_head [`PIO_NUM_SM];
  pio_pkg::word_t         pin_val [`PIO_NUM_SM];
  pio_pkg::word_t         pin_mask [`PIO_NUM_SM];

  assign dout = rx_head[mindex];

  pio_ctrl u_ctrl (
    .clk(clk), .reset(reset), .action(action), .mindex(mindex), .index(index), .din(din),
    .pc(pc), .instr_word(instr_word), .imm_stb(imm_stb), .imm_instr(imm_instr),
    .sm_en(sm_en), .wrap_start(wrap_start), .wrap_end(wrap_end),
    .out_base(out_base), .out_count(out_count), .set_base(set_base), .set_count(set_count),
    .jmp_pin_idx(jmp_pin_idx), .div(div), .host_push(host_push), .host_pop(host_pop)
  );

  for (genvar i = 0; i < `PIO_NUM_SM; i++) begin : g_sm
    pio_fifo u_tx (
      .clk(clk), .reset(reset), .push(host_push[i]), .pop(sm_pull[i]), .din(din),
      .dout(tx_data[i]), .empty(tx_empty[i]), .full(tx_full[i])
    );

    pio_fifo u_rx (
      .clk(clk), .reset(reset), .push(sm_push[i]), .pop(host_pop[i]), .din(rx_data[i]),
      .dout(rx_head[i]), .empty(rx_empty[i]), .full(rx_full[i])
    );

    pio_machine u_sm (
      .clk(clk), .reset(reset), .en(sm_en[i]), .imm_stb(imm_stb[i]), .imm_instr(imm_instr),
      .instr_word(instr_word[i]), .wrap_start(wrap_start[i]), .wrap_end(wrap_end[i]),
      .out_base(out_base[i]), .out_count(out_count[i]), .set_base(set_base[i]),
      .set_count(set_count[i]), .jmp_pin_idx(jmp_pin_idx[i]), .div(div[i]),
      .gpio_in(gpio_in), .tx_data(tx_data[i]), .tx_empty(tx_empty[i]), .rx_full(rx_full[i]),
      .pc(pc[i]), .pull(sm_pull[i]), .push(sm_push[i]), .rx_data(rx_data[i]),
      .pin_val(pin_val[i]), .pin_mask(pin_mask[i])
    );
  end

  pio_pin_merge u_merge (
    .pin_val(pin_val), .pin_mask(pin_mask), .gpio_out(gpio_out), .gpio_dir(gpio_dir)
  );

endmodule

/* tb/pio_clock_gen.sv */
`timescale 1ns/1ps

module pio_clock_gen (
  output logic clk
);

  localparam real HALF_PERIOD = 2.0;  // 4 ns period

  initial begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

/* tb/pio_tb.sv */
`timescale 1ns/1ps
`include "pio_macros.svh"

module pio_tb;

  localparam int N_ECHO  = 16;
  localparam int N_COUNT = 8;
  localparam int N_JUMP  = 6;
  localparam int N_FULL  = 2 * `PIO_FIFO_DEPTH + 1;  // Both FIFOs plus the stalled ISR
  // About 20 steps per word at divider 7, three times over
  localparam int TIMEOUT_CYCLES = 3 * 170 * (N_ECHO + N_COUNT + N_JUMP + N_FULL);

  logic                     clk;
  logic                     reset;
  logic [3:0]               action;
  logic [`PIO_SM_IDX_W-1:0] mindex;
  logic [`PIO_PC_W-1:0]     index;
  logic [31:0]              din;
  logic [31:0]              gpio_in;
  logic [31:0]              dout;
  logic [`PIO_NUM_SM-1:0]   tx_full;
  logic [`PIO_NUM_SM-1:0]   rx_empty;
  logic [31:0]              gpio_out;
  logic [31:0]              gpio_dir;
  logic [15:0]              lfsr = 16'd19689;
  logic [31:0]              tx_q [$];
  logic [31:0]              exp_q [$];
  int                       cycles = 0;
  int                       errors = 0;
  int                       checks = 0;
  int                       failed_tests = 0;

  pio_clock_gen u_clk (.clk(clk));

  pio u_pio (
    .clk(clk), .reset(reset), .action(action), .mindex(mindex), .index(index), .din(din),
    .gpio_in(gpio_in), .dout(dout), .tx_full(tx_full), .rx_empty(rx_empty),
    .gpio_out(gpio_out), .gpio_dir(gpio_dir)
  );

  assign gpio_in = gpio_out;  // Pins loop back

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: a test was still waiting on the DUT after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // Taps 16, 14, 13, 11
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic host(logic [3:0] act, int m, int idx, logic [31:0] d);
    action = act;
    mindex = m[`PIO_SM_IDX_W-1:0];
    index  = idx[`PIO_PC_W-1:0];
    din    = d;
    step();
    action = pio_pkg::ACT_IDLE;
  endtask

  task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic end_test(string name, int errors_before);
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  // One host action per cycle, pops take precedence
  task automatic run_stream(int m, string name);
    int sent;
    sent = 0;
    mindex = m[`PIO_SM_IDX_W-1:0];
    step();
    while (exp_q.size() > 0) begin
      if (!rx_empty[m]) begin
        check(name, exp_q.pop_front(), dout);
        action = pio_pkg::ACT_POP_RX;
      end else if (sent < tx_q.size() && !tx_full[m]) begin
        din = tx_q[sent];
        sent++;
        action = pio_pkg::ACT_PUSH_TX;
      end else begin
        action = pio_pkg::ACT_IDLE;
      end
      step();
    end
    action = pio_pkg::ACT_IDLE;
    tx_q.delete();
  endtask

  initial begin
    int          err0;
    int          b2;
    int          b3;
    int          pin;
    logic        hold;
    logic [31:0] v;
    logic [31:0] v3;
    logic [31:0] m2;
    logic [31:0] m3;
    reset  = 1'b1;
    action = pio_pkg::ACT_IDLE;
    mindex = '0;
    index  = '0;
    din    = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    err0 = errors;
    host(pio_pkg::ACT_WR_INSTR, 0, 0, 32'h8020);  // PULL
    host(pio_pkg::ACT_WR_INSTR, 0, 1, 32'h6008);  // OUT pins 8
    host(pio_pkg::ACT_WR_INSTR, 0, 2, 32'h4008);  // IN pins 8
    host(pio_pkg::ACT_WR_INSTR, 0, 3, 32'h8000);  // PUSH
    host(pio_pkg::ACT_WRAP, 0, 3, 32'd0);
    host(pio_pkg::ACT_PINS, 0, 0, 32'(8 << 5));  // Out base 0, 8 pins
    host(pio_pkg::ACT_DIV, 0, 0, rand_bits(3));
    host(pio_pkg::ACT_ENABLE, 0, 0, 32'h1);
    for (int i = 0; i < N_ECHO; i++) begin
      v = rand_bits(32);
      tx_q.push_back(v);
      exp_q.push_back(v & 32'hFF);
    end
    run_stream(0, "echo");
    end_test("echo", err0);

    err0 = errors;
    host(pio_pkg::ACT_WR_INSTR, 0, 4, 32'h8020);  // PULL
    host(pio_pkg::ACT_WR_INSTR, 0, 5, 32'h6020);  // OUT x 32
    host(pio_pkg::ACT_WR_INSTR, 0, 6, 32'h0046);  // JMP x-- to self
    host(pio_pkg::ACT_WR_INSTR, 0, 7, 32'h4020);  // IN x 32
    host(pio_pkg::ACT_WR_INSTR, 0, 8, 32'h8000);  // PUSH
    host(pio_pkg::ACT_WRAP, 1, 8, 32'd4);
    host(pio_pkg::ACT_IMM, 1, 0, 32'h0004);
    host(pio_pkg::ACT_ENABLE, 0, 0, 32'h3);
    for (int i = 0; i < N_COUNT; i++) begin
      tx_q.push_back(rand_bits(4));
      exp_q.push_back(32'hFFFF_FFFF);  // x runs one past zero
    end
    run_stream(1, "countdown");
    end_test("countdown", err0);

    err0 = errors;
    pin = 8 + int'(rand_bits(4));  // Clear of the echo pins
    host(pio_pkg::ACT_WR_INSTR, 0, 9, 32'h8020);  // PULL
    host(pio_pkg::ACT_WR_INSTR, 0, 10, 32'h2020 | 32'(pin + 1));  // WAIT gate pin high
    host(pio_pkg::ACT_WR_INSTR, 0, 11, 32'h006E);  // JMP pin 14
    host(pio_pkg::ACT_WR_INSTR, 0, 12, 32'hE020);  // SET x 0
    host(pio_pkg::ACT_WR_INSTR, 0, 13, 32'h000F);  // JMP 15
    host(pio_pkg::ACT_WR_INSTR, 0, 14, 32'hE021);  // SET x 1
    host(pio_pkg::ACT_WR_INSTR, 0, 15, 32'h4020);  // IN x 32
    host(pio_pkg::ACT_WR_INSTR, 0, 16, 32'h8000);  // PUSH
    host(pio_pkg::ACT_PINS, 0, 0, 32'((2 << 16) | (pin << 11) | (8 << 5)));
    host(pio_pkg::ACT_JMP_PIN, 0, 0, 32'(pin));
    host(pio_pkg::ACT_WRAP, 0, 16, 32'd9);
    host(pio_pkg::ACT_IMM, 0, 0, 32'h0009);
    for (int t = 0; t < N_JUMP; t++) begin
      v = rand_bits(1);
      host(pio_pkg::ACT_IMM, 0, 0, 32'hE000 | v);  // Gate pin low
      host(pio_pkg::ACT_PUSH_TX, 0, 0, rand_bits(32));
      repeat (32) begin
        step();
      end
      check("jump_pin", 32'h1, 32'(rx_empty[0]));  // Still held by WAIT
      host(pio_pkg::ACT_IMM, 0, 0, 32'hE002 | v);
      while (rx_empty[0]) begin
        step();
      end
      check("jump_pin", v, dout);
      host(pio_pkg::ACT_POP_RX, 0, 0, 32'd0);
    end
    end_test("jump_pin", err0);

    err0 = errors;
    for (int i = 0; i < N_FULL; i++) begin
      while (tx_full[1]) begin
        step();
      end
      host(pio_pkg::ACT_PUSH_TX, 1, 0, rand_bits(2));
      exp_q.push_back(32'hFFFF_FFFF);
    end
    while (!tx_full[1]) begin
      step();
    end
    hold = 1'b1;
    repeat (64) begin
      hold = hold & tx_full[1];
      step();
    end
    check("backpressure", 32'h1, 32'(hold));
    check("backpressure", 32'h0, 32'(rx_empty[1]));
    run_stream(1, "backpressure");
    end_test("backpressure", err0);

    err0 = errors;
    b2 = int'(rand_bits(5)) % 28;
    v = rand_bits(5);
    host(pio_pkg::ACT_PINS, 2, 0, 32'((5 << 16) | (b2 << 11)));
    host(pio_pkg::ACT_IMM, 2, 0, 32'hE000 | v);
    step();
    m2 = 32'h1F << b2;
    check("imm_set", v << b2, gpio_out & m2);
    check("imm_set", m2, gpio_dir & m2);
    end_test("imm_set", err0);

    err0 = errors;
    b2 = int'(rand_bits(5)) % 24;
    b3 = b2 + int'(rand_bits(2));  // At least two shared pins
    v = rand_bits(5);
    v3 = rand_bits(5);
    host(pio_pkg::ACT_PINS, 2, 0, 32'((5 << 16) | (b2 << 11)));
    host(pio_pkg::ACT_PINS, 3, 0, 32'((5 << 16) | (b3 << 11)));
    host(pio_pkg::ACT_IMM, 2, 0, 32'hE000 | v);
    host(pio_pkg::ACT_IMM, 3, 0, 32'hE000 | v3);
    step();
    m2 = 32'h1F << b2;
    m3 = 32'h1F << b3;
    check("pin_priority", ((v << b2) & ~m3) | (v3 << b3), gpio_out & (m2 | m3));
    check("pin_priority", m2 | m3, gpio_dir & (m2 | m3));
    end_test("pin_priority", err0);

    $display("Tests: 6, failed: %0d, checks: %0d, errors: %0d", failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* pio.f */
+incdir+include
src/pio_pkg.sv
src/pio_ctrl.sv
src/pio_fifo.sv
src/pio_machine.sv
src/pio_pin_merge.sv
src/pio.sv
tb/pio_clock_gen.sv
tb/pio_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pio_tb -f pio.f -o pio_sim \
  && ./obj_dir/pio_sim > sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
